/* build.f */
+incdir+.
elink_tx_pkg.sv
emesh_classifier.sv
emesh_tx_fifo.sv
tx_arbiter.sv
eproto_tx.sv
elink_tx_top.sv
tb_elink_tx.sv

/* elink_tx_macros.svh */
/*
  Tunable FIFO depth and frame mask codes for the eLink transmit path.
  Include in any block that sizes a FIFO or drives the frame lanes.
*/
`ifndef ELINK_TX_MACROS_SVH
`define ELINK_TX_MACROS_SVH

// ############################################################
// Sizing
// ############################################################

// Entries per class FIFO, keep to a power of two
`define ELINK_TX_FIFO_DEPTH 4

// ############################################################
// Frame masks, one bit per byte lane
// ############################################################

// Header beat, low six bytes carry the transaction header
`define ELINK_FRAME_HEAD 8'h3F

// Data beat, all eight bytes valid
`define ELINK_FRAME_DATA 8'hFF

// Idle cycle
`define ELINK_FRAME_IDLE 8'h00

`endif

/* elink_tx_pkg.sv */
/*
  Shared types for the eLink transmit path: mesh transaction, beat views
  and the write/read class indices. Imported by every block of the path.
*/
package elink_tx_pkg;

  // ############################################################
  // Traffic classes
  // ############################################################
  localparam int NUM_CLASSES = 2;                // Writes and read requests
  localparam int CLASS_W     = $clog2(NUM_CLASSES);

  typedef logic [CLASS_W-1:0] class_idx_t;

  localparam class_idx_t CLASS_WR = class_idx_t'(0); // write = 1
  localparam class_idx_t CLASS_RD = class_idx_t'(1); // write = 0

  // One mesh transaction, strobe travels beside it
  typedef struct packed {
    logic        write;
    logic [1:0]  datamode;
    logic [3:0]  ctrlmode;
    logic [31:0] dstaddr;
    logic [31:0] srcaddr;
    logic [31:0] data;
  } emesh_txn_t;

  // ############################################################
  // Parallel beat views
  // ############################################################

  // Header beat, byte order as seen by the serializer
  typedef struct packed {
    logic [15:0] unused;    // Top two bytes, not sent
    logic        rd_flag;   // B0, inverted write
    logic [6:0]  rsvd;      // B0, burst bits later
    logic [3:0]  ctrlmode;
    logic [31:0] dstaddr;   // Spans B1 to B5
    logic [1:0]  datamode;
    logic        write;
    logic        access;    // Always set on a header
  } tx_head_t;

  // Data beat
  typedef struct packed {
    logic [31:0] data;
    logic [31:0] srcaddr;
  } tx_body_t;

  // Same 64-bit word, decoded per frame type
  typedef union packed {
    tx_head_t head;
    tx_body_t body;
  } tx_beat_u;

endpackage

/* elink_tx_top.sv */
/*
  Transmit side of the mesh link: classifier, per-class FIFOs, arbiter
  and protocol encoder. Drives parallel beats for an external serializer.
*/
`timescale 1ns/1ps

module elink_tx_top (
  input  logic                      txlclk_p,
  input  logic                      reset,
  input  logic                      emesh_access,
  input  elink_tx_pkg::emesh_txn_t  emesh_txn,
  output logic                      emesh_wr_wait,  // Upstream back-pressure
  output logic                      emesh_rd_wait,
  input  logic                      tx_wr_wait,
  input  logic                      tx_rd_wait,
  output logic [7:0]                txframe_p,
  output elink_tx_pkg::tx_beat_u    txdata_p
);

  import elink_tx_pkg::*;

  logic                               push;
  class_idx_t                         class_sel;
  emesh_txn_t                         push_txn;
  logic       [NUM_CLASSES-1:0]       fifo_empty;
  logic       [NUM_CLASSES-1:0]       fifo_full;
  logic       [NUM_CLASSES-1:0]       pop;
  emesh_txn_t [NUM_CLASSES-1:0]       fifo_head;
  logic                               arb_access;
  emesh_txn_t                         arb_txn;
  logic                               emtx_ack;
  logic                               wr_wait_sync;
  logic                               rd_wait_sync;

  // ############################################################
  // Input side
  // ############################################################
  emesh_classifier classifier_inst (
    .txlclk_p     (txlclk_p),
    .reset        (reset),
    .emesh_access (emesh_access),
    .emesh_txn    (emesh_txn),
    .push         (push),
    .class_sel    (class_sel),
    .push_txn     (push_txn)
  );

  for (genvar c = 0; c < NUM_CLASSES; c++) begin : g_fifo
    emesh_tx_fifo fifo_inst (
      .txlclk_p (txlclk_p),
      .reset    (reset),
      .push     (push && class_sel == class_idx_t'(c)), // Own class only
      .pop      (pop[c]),
      .push_txn (push_txn),
      .head     (fifo_head[c]),
      .empty    (fifo_empty[c]),
      .full     (fifo_full[c])
    );
  end

  // ############################################################
  // Output side
  // ############################################################
  tx_arbiter arbiter_inst (
    .txlclk_p     (txlclk_p),
    .reset        (reset),
    .fifo_empty   (fifo_empty),
    .fifo_head    (fifo_head),
    .wr_wait_sync (wr_wait_sync),
    .rd_wait_sync (rd_wait_sync),
    .emtx_ack     (emtx_ack),
    .pop          (pop),
    .arb_access   (arb_access),
    .arb_txn      (arb_txn)
  );

  eproto_tx proto_inst (
    .txlclk_p     (txlclk_p),
    .reset        (reset),
    .arb_access   (arb_access),
    .arb_txn      (arb_txn),
    .tx_wr_wait   (tx_wr_wait),
    .tx_rd_wait   (tx_rd_wait),
    .emtx_ack     (emtx_ack),
    .txframe_p    (txframe_p),
    .txdata_p     (txdata_p),
    .wr_wait_sync (wr_wait_sync),
    .rd_wait_sync (rd_wait_sync)
  );

  // Remote wait or no room left in the queue
  assign emesh_wr_wait = wr_wait_sync | fifo_full[CLASS_WR];
  assign emesh_rd_wait = rd_wait_sync | fifo_full[CLASS_RD];

endmodule

/* emesh_classifier.sv */
/*
  Input stage of the transmit path. Registers each mesh transaction and
  steers it to the class FIFO picked by its write bit.
*/
`timescale 1ns/1ps

module emesh_classifier (
  input  logic                      txlclk_p,
  input  logic                      reset,
  input  logic                      emesh_access,  // One-cycle strobe
  input  elink_tx_pkg::emesh_txn_t  emesh_txn,
  output logic                      push,          // One cycle after strobe
  output elink_tx_pkg::class_idx_t  class_sel,
  output elink_tx_pkg::emesh_txn_t  push_txn
);

  import elink_tx_pkg::*;

  class_idx_t txn_class; // Class of the incoming word

  // Writes and read requests go to separate queues
  assign txn_class = emesh_txn.write ? CLASS_WR : CLASS_RD;

  // ############################################################
  // Strobe and class
  // ############################################################
  always_ff @(posedge txlclk_p) begin
    if (reset) begin
      push      <= 1'b0;
      class_sel <= CLASS_WR;
    end else begin
      push      <= emesh_access;
      if (emesh_access) begin
        class_sel <= txn_class; // Hold last class between pushes
      end
    end
  end

  // Payload, captured on every strobe
  always_ff @(posedge txlclk_p) begin
    if (emesh_access) begin
      push_txn <= emesh_txn;
    end
  end

endmodule

/* emesh_tx_fifo.sv */
/*
  Per-class transaction queue with empty and full flags.
  The top builds one copy per class, head is read without a pop delay.
*/
`timescale 1ns/1ps
`include "elink_tx_macros.svh"

module emesh_tx_fifo #(
  parameter int DEPTH = `ELINK_TX_FIFO_DEPTH
) (
  input  logic                      txlclk_p,
  input  logic                      reset,
  input  logic                      push,
  input  logic                      pop,
  input  elink_tx_pkg::emesh_txn_t  push_txn,
  output elink_tx_pkg::emesh_txn_t  head,     // Oldest entry
  output logic                      empty,
  output logic                      full
);

  import elink_tx_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  emesh_txn_t       mem [DEPTH];  // Storage, no reset
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;        // Occupancy
  logic             do_push;
  logic             do_pop;

  assign do_push = push & ~full;  // Dropped when full
  assign do_pop  = pop & ~empty;

  assign empty = (count == '0);
  assign full  = (count == CNT_W'(DEPTH));
  assign head  = mem[rd_ptr];

  // ############################################################
  // Pointers and occupancy
  // ############################################################
  always_ff @(posedge txlclk_p) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;  // Wraps, depth is a power of two
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Idle or push with pop
      endcase
    end
  end

  // Entry write
  always_ff @(posedge txlclk_p) begin
    if (do_push) begin
      mem[wr_ptr] <= push_txn;
    end
  end

endmodule

/* eproto_tx.sv */
/*
  Protocol encoder. Turns one transaction into a header beat and a data
  beat for the serializer, and brings the remote waits into this clock.
*/
`timescale 1ns/1ps
`include "elink_tx_macros.svh"

module eproto_tx (
  input  logic                      txlclk_p,
  input  logic                      reset,
  input  logic                      arb_access,    // Level from arbiter
  input  elink_tx_pkg::emesh_txn_t  arb_txn,
  input  logic                      tx_wr_wait,    // Remote, async
  input  logic                      tx_rd_wait,    // Remote, async
  output logic                      emtx_ack,      // With the header beat
  output logic [7:0]                txframe_p,
  output elink_tx_pkg::tx_beat_u    txdata_p,
  output logic                      wr_wait_sync,
  output logic                      rd_wait_sync
);

  import elink_tx_pkg::*;

  tx_head_t head_beat;
  tx_body_t body_beat;
  logic     wr_wait_meta;  // First sync stage
  logic     rd_wait_meta;

  // ############################################################
  // Beat contents
  // ############################################################
  always_comb begin
    head_beat          = '0;
    head_beat.rd_flag  = ~arb_txn.write;
    head_beat.ctrlmode = arb_txn.ctrlmode;
    head_beat.dstaddr  = arb_txn.dstaddr;
    head_beat.datamode = arb_txn.datamode;
    head_beat.write    = arb_txn.write;
    head_beat.access   = arb_access;  // High whenever a header goes out
  end

  always_comb begin
    body_beat.data    = arb_txn.data;
    body_beat.srcaddr = arb_txn.srcaddr;
  end

  // ############################################################
  // Two-beat sequencer
  // ############################################################
  always_ff @(posedge txlclk_p) begin
    if (reset) begin
      emtx_ack  <= 1'b0;
      txframe_p <= `ELINK_FRAME_IDLE;
      txdata_p  <= '0;
    end else if (arb_access && !emtx_ack) begin
      // New transaction, header first
      emtx_ack      <= 1'b1;
      txframe_p     <= `ELINK_FRAME_HEAD;
      txdata_p.head <= head_beat;
    end else if (emtx_ack) begin
      // Second beat, txn still held by arbiter
      emtx_ack      <= 1'b0;
      txframe_p     <= `ELINK_FRAME_DATA;
      txdata_p.body <= body_beat;
    end else begin
      emtx_ack  <= 1'b0;
      txframe_p <= `ELINK_FRAME_IDLE;
      txdata_p  <= '0;  // Quiet lanes
    end
  end

  // ############################################################
  // Remote wait synchronizers
  // ############################################################
  always_ff @(posedge txlclk_p) begin
    if (reset) begin
      wr_wait_meta <= 1'b0;
      wr_wait_sync <= 1'b0;
      rd_wait_meta <= 1'b0;
      rd_wait_sync <= 1'b0;
    end else begin
      wr_wait_meta <= tx_wr_wait;
      wr_wait_sync <= wr_wait_meta;  // Two cycles from pin
      rd_wait_meta <= tx_rd_wait;
      rd_wait_sync <= rd_wait_meta;
    end
  end

endmodule

/* tb_elink_tx.sv */
/*
  Self-checking testbench for the transmit path. Random traffic from an LFSR,
  one model queue per class, and a beat monitor on the serializer lanes.
*/
`timescale 1ns/1ps
`include "elink_tx_macros.svh"

module tb_elink_tx;

  import elink_tx_pkg::*;

  localparam int NUM_TXN     = 200;
  localparam int STIM_LIMIT  = 20000;  // Cycles for the whole issue phase
  localparam int DRAIN_LIMIT = 2000;

  logic       txlclk_p;
  logic       reset;
  logic       emesh_access;
  emesh_txn_t emesh_txn;
  logic       emesh_wr_wait;
  logic       emesh_rd_wait;
  logic       tx_wr_wait;
  logic       tx_rd_wait;
  logic [7:0] txframe_p;
  tx_beat_u   txdata_p;

  logic [31:0] lfsr_state = 32'd71992;
  emesh_txn_t  wr_q[$];                 // Model queue of writes
  emesh_txn_t  rd_q[$];                 // Model queue of reads
  int          errors = 0;
  int          issued = 0;
  int          received = 0;
  logic        mon_on = 1'b0;
  logic        body_due = 1'b0;         // Data beat expected next
  logic        body_wr;                 // Class of that data beat
  logic [1:0]  wr_hist = '0;            // Remote wait pins over the last two cycles
  logic [1:0]  rd_hist = '0;
  int          wr_held = 0;             // Headers seen while class waits
  int          rd_held = 0;

  elink_tx_top elink_tx_top_inst (
    .txlclk_p      (txlclk_p),
    .reset         (reset),
    .emesh_access  (emesh_access),
    .emesh_txn     (emesh_txn),
    .emesh_wr_wait (emesh_wr_wait),
    .emesh_rd_wait (emesh_rd_wait),
    .tx_wr_wait    (tx_wr_wait),
    .tx_rd_wait    (tx_rd_wait),
    .txframe_p     (txframe_p),
    .txdata_p      (txdata_p)
  );

  initial begin
    txlclk_p = 1'b0;
    forever #5 txlclk_p = ~txlclk_p;  // 100 MHz
  end

  // ############################################################
  // Helpers
  // ############################################################

  // Galois LFSR with taps 32 22 2 1
  function automatic logic next_bit();
    logic lsb;
    lsb        = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (lsb) begin
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return lsb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], next_bit()};  // One step per bit
    end
    return v;
  endfunction

  function automatic emesh_txn_t random_txn(input logic write);
    emesh_txn_t t;
    t.write    = write;
    t.datamode = 2'(rand_bits(2));
    t.ctrlmode = 4'(rand_bits(4));
    t.dstaddr  = rand_bits(32);
    t.srcaddr  = rand_bits(32);
    t.data     = rand_bits(32);
    return t;
  endfunction

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("error at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // ############################################################
  // Beat monitor sampling the lanes before each edge updates them
  // ############################################################
  always @(posedge txlclk_p) begin
    tx_head_t   hd;
    tx_body_t   bd;
    emesh_txn_t exp_txn;
    logic       wr_sync;
    logic       rd_sync;
    logic       is_head;
    if (mon_on) begin
      wr_sync = wr_hist[1];                     // Pin value two cycles back
      rd_sync = rd_hist[1];
      wr_hist = {wr_hist[0], tx_wr_wait};
      rd_hist = {rd_hist[0], tx_rd_wait};
      if (wr_sync) check_value("emesh_wr_wait", emesh_wr_wait, 1'b1);
      if (rd_sync) check_value("emesh_rd_wait", emesh_rd_wait, 1'b1);
      is_head = !body_due && (txframe_p == `ELINK_FRAME_HEAD);
      if (body_due) begin
        check_value("data frame", txframe_p, `ELINK_FRAME_DATA);
        bd       = txdata_p.body;
        body_due = 1'b0;
        if (body_wr ? wr_q.size() == 0 : rd_q.size() == 0) begin
          errors++;
          $display("Data beat at %0d ns has no pending transaction", $time);
        end else begin
          exp_txn = body_wr ? wr_q.pop_front() : rd_q.pop_front();  // Done with it
          check_value("data", bd.data, exp_txn.data);
          check_value("srcaddr", bd.srcaddr, exp_txn.srcaddr);
        end
      end else if (is_head) begin
        hd       = txdata_p.head;
        body_due = 1'b1;
        body_wr  = hd.write;                    // Class follows write bit
        received++;
        if (hd.write ? wr_q.size() == 0 : rd_q.size() == 0) begin
          errors++;
          $display("Header at %0d ns has no pending transaction", $time);
        end else begin
          exp_txn = hd.write ? wr_q[0] : rd_q[0];
          check_value("datamode", hd.datamode, exp_txn.datamode);
          check_value("ctrlmode", hd.ctrlmode, exp_txn.ctrlmode);
          check_value("dstaddr", hd.dstaddr, exp_txn.dstaddr);
          check_value("access", hd.access, 1'b1);
          check_value("rd_flag", hd.rd_flag, !exp_txn.write);
        end
      end else begin
        check_value("idle frame", txframe_p, `ELINK_FRAME_IDLE);
        check_value("idle data", txdata_p, 64'h0);
      end
      // Only the grant already made may pass a raised wait
      wr_held = !wr_sync ? 0 : wr_held + int'(is_head && hd.write);
      rd_held = !rd_sync ? 0 : rd_held + int'(is_head && !hd.write);
      if (wr_held > 1 || rd_held > 1) begin
        errors++;
        $display("Second header of a waiting class sent at %0d ns", $time);
        wr_held = 0;
        rd_held = 0;
      end
    end
  end

  // ############################################################
  // Stimulus
  // ############################################################
  initial begin
    int         cycles;
    int         gap;                            // Spacing so full is seen
    int         wr_run;
    int         rd_run;
    logic       cls_write;
    emesh_txn_t txn;
    reset        <= 1'b1;
    emesh_access <= 1'b0;
    emesh_txn    <= '0;
    tx_wr_wait   <= 1'b0;
    tx_rd_wait   <= 1'b0;
    repeat (5) @(posedge txlclk_p);
    reset <= 1'b0;
    repeat (3) @(posedge txlclk_p);
    check_value("frame after reset", txframe_p, `ELINK_FRAME_IDLE);
    check_value("data after reset", txdata_p, 64'h0);
    check_value("wr wait after reset", emesh_wr_wait, 1'b0);
    check_value("rd wait after reset", emesh_rd_wait, 1'b0);
    mon_on <= 1'b1;

    cycles = 0;
    gap    = 0;
    wr_run = 0;
    rd_run = 0;
    while (issued < NUM_TXN && cycles < STIM_LIMIT) begin
      @(posedge txlclk_p);
      cycles++;
      if (wr_run == 0) begin
        tx_wr_wait <= (rand_bits(2) == 32'd0);  // Stall one run in four
        wr_run = 16 + int'(rand_bits(5));
      end else begin
        wr_run--;
      end
      if (rd_run == 0) begin
        tx_rd_wait <= (rand_bits(2) == 32'd0);
        rd_run = 16 + int'(rand_bits(5));
      end else begin
        rd_run--;
      end
      emesh_access <= 1'b0;
      if (gap > 0) begin
        gap--;
      end else begin
        cls_write = next_bit();
        if (cls_write ? !emesh_wr_wait : !emesh_rd_wait) begin
          txn = random_txn(cls_write);
          emesh_access <= 1'b1;
          emesh_txn    <= txn;
          if (cls_write) wr_q.push_back(txn);
          else rd_q.push_back(txn);
          issued++;
          gap = 2 + int'(rand_bits(2));
        end
      end
    end
    @(posedge txlclk_p);
    emesh_access <= 1'b0;
    tx_wr_wait   <= 1'b0;
    tx_rd_wait   <= 1'b0;
    if (issued < NUM_TXN) begin
      errors++;
      $display("Stimulus stalled, only %0d of %0d transactions issued", issued, NUM_TXN);
    end

    // Drain sampled away from the active edge
    cycles = 0;
    while ((wr_q.size() != 0 || rd_q.size() != 0 || body_due) && cycles < DRAIN_LIMIT) begin
      @(negedge txlclk_p);
      cycles++;
    end
    if (wr_q.size() != 0 || rd_q.size() != 0) begin
      errors++;
      $display("Drain timed out, %0d writes and %0d reads never sent",
               wr_q.size(), rd_q.size());
    end
    repeat (4) @(negedge txlclk_p);           // Lanes must stay idle

    $display("Issued %0d, received %0d, errors %0d", issued, received, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* tx_arbiter.sv */
/*
  Round-robin arbiter over the class FIFOs. Skips waiting classes, holds
  the granted transaction until the encoder acks, then pops its FIFO.
*/
`timescale 1ns/1ps

module tx_arbiter (
  input  logic                                                    txlclk_p,
  input  logic                                                    reset,
  input  logic [elink_tx_pkg::NUM_CLASSES-1:0]                    fifo_empty,
  input  elink_tx_pkg::emesh_txn_t [elink_tx_pkg::NUM_CLASSES-1:0] fifo_head,
  input  logic                                                    wr_wait_sync,
  input  logic                                                    rd_wait_sync,
  input  logic                                                    emtx_ack,
  output logic [elink_tx_pkg::NUM_CLASSES-1:0]                    pop,
  output logic                                                    arb_access,
  output elink_tx_pkg::emesh_txn_t                                arb_txn
);

  import elink_tx_pkg::*;

  logic [NUM_CLASSES-1:0] cls_wait;  // Remote wait per class
  logic [NUM_CLASSES-1:0] eligible;
  logic                   load_ok;   // Free or finishing this cycle
  logic                   pick_valid;
  class_idx_t             pick;
  class_idx_t             grant;     // Class currently presented
  class_idx_t             rr_ptr;    // First class to look at

  assign cls_wait[CLASS_WR] = wr_wait_sync;
  assign cls_wait[CLASS_RD] = rd_wait_sync;

  assign load_ok = ~arb_access | emtx_ack;

  // ############################################################
  // Eligibility and round-robin pick
  // ############################################################
  always_comb begin
    for (int c = 0; c < NUM_CLASSES; c++) begin
      // Class being popped right now still shows its old head
      eligible[c] = ~fifo_empty[c] & ~cls_wait[c]
                    & ~(arb_access && grant == class_idx_t'(c));
      pop[c]      = arb_access & emtx_ack & (grant == class_idx_t'(c));
    end
  end

  always_comb begin
    class_idx_t cand;
    pick       = rr_ptr;
    pick_valid = 1'b0;
    // Walk backwards so the nearest class to rr_ptr wins
    for (int i = NUM_CLASSES - 1; i >= 0; i--) begin
      cand = class_idx_t'((int'(rr_ptr) + i) % NUM_CLASSES);
      if (eligible[cand]) begin
        pick       = cand;
        pick_valid = 1'b1;
      end
    end
  end

  // ############################################################
  // Grant state
  // ############################################################
  always_ff @(posedge txlclk_p) begin
    if (reset) begin
      arb_access <= 1'b0;
      grant      <= CLASS_WR;
      rr_ptr     <= CLASS_WR;
    end else if (load_ok) begin
      arb_access <= pick_valid;  // Drops on ack unless a new one is ready
      if (pick_valid) begin
        grant  <= pick;
        rr_ptr <= class_idx_t'((int'(pick) + 1) % NUM_CLASSES); // Past winner
      end
    end
  end

  // Held steady through the ack cycle
  always_ff @(posedge txlclk_p) begin
    if (load_ok && pick_valid) begin
      arb_txn <= fifo_head[pick];
    end
  end

endmodule
